/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= No errors

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/if_stage_asserts.sv */
// bus and pipeline protocol assertions, bound to the fetch stage top level

`timescale 1ns/1ps
`default_nettype none

module if_stage_asserts (
  input logic          clk_i,
  input logic          rst_ni,
  input logic          instr_req_o,
  input if_pkg::addr_t instr_addr_o,
  input logic          instr_gnt_i,
  input logic          csr_mtvec_init_o,
  input logic          pc_set_i,
  input logic          instr_new_id_o,
  input logic          instr_valid_id_o,
  input if_pkg::addr_t pc_id_o
);

  int fail_count = 0;

  // an ungranted request keeps its address
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      fail_count++;
      $error("request dropped or address changed before grant");
    end

  mtvec_init_on_set: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o |-> pc_set_i)
    else begin
      fail_count++;
      $error("mtvec init without a PC change");
    end

  // the decode PC moves only with a new instruction
  pc_id_on_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $changed(pc_id_o) |-> instr_new_id_o)
    else begin
      fail_count++;
      $error("pc_id_o changed without an accepted word");
    end

  valid_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !instr_valid_id_o)
    else begin
      fail_count++;
      $error("valid flag high right after reset");
    end

endmodule

bind if_stage if_stage_asserts u_asserts (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .instr_req_o      (instr_req_o),
  .instr_addr_o     (instr_addr_o),
  .instr_gnt_i      (instr_gnt_i),
  .csr_mtvec_init_o (csr_mtvec_init_o),
  .pc_set_i         (pc_set_i),
  .instr_new_id_o   (instr_new_id_o),
  .instr_valid_id_o (instr_valid_id_o),
  .pc_id_o          (pc_id_o)
);

`default_nettype wire

/* bench/tb_if_stage.sv */
// testbench for the instruction fetch stage
// bus memory model, reference functions, comparing process and directed sequence

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  localparam logic [31:0] DATA_KEY = 32'h5A3C_96E1;
  // four bus error words
  localparam logic [31:0] ERR_LO   = 32'h0000_3000;

  logic clk_i;
  logic rst_ni, req_i, pc_set, id_in_ready_i, instr_valid_clear_i;
  logic [31:0] boot_addr, branch_target, mepc, mtvec;
  if_pkg::pc_sel_e     pc_mux;
  if_pkg::exc_pc_sel_e exc_mux;
  logic [if_pkg::IRQ_ID_W-1:0] irq_id;
  logic        csr_mtvec_init_o, instr_req_o, instr_valid_id_o, instr_new_id_o;
  logic        instr_fetch_err_o, if_busy_o;
  logic [31:0] instr_addr_o, instr_rdata_id_o, pc_id_o, pc_if_o;
  logic        instr_gnt_i = 1'b0;
  logic        instr_rvalid_i = 1'b0;
  logic        instr_err_i = 1'b0;
  logic [31:0] instr_rdata_i = '0;

  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q  [$];
  int cyc = 0;
  int gnt_wait = 0;
  int last_due = 0;
  logic [31:0] exp_pc = '0;
  // FIFO head address seen at the previous clock edge
  logic [31:0] last_pc_if = '0;
  int new_count = 0;
  int err_seen = 0;
  int value_errs = 0;
  int step_errs = 0;
  int timeouts = 0;
  logic rand_ready;

  if_stage uut (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req_i), .boot_addr_i (boot_addr),
    .pc_set_i (pc_set), .pc_mux_i (pc_mux), .exc_pc_mux_i (exc_mux), .irq_id_i (irq_id),
    .branch_target_i (branch_target), .csr_mepc_i (mepc), .csr_mtvec_i (mtvec),
    .csr_mtvec_init_o (csr_mtvec_init_o), .instr_req_o (instr_req_o),
    .instr_addr_o (instr_addr_o), .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i), .instr_err_i (instr_err_i), .id_in_ready_i (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i), .instr_valid_id_o (instr_valid_id_o),
    .instr_new_id_o (instr_new_id_o), .instr_rdata_id_o (instr_rdata_id_o),
    .instr_fetch_err_o (instr_fetch_err_o), .pc_id_o (pc_id_o), .pc_if_o (pc_if_o),
    .if_busy_o (if_busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return addr ^ DATA_KEY;
  endfunction

  function automatic logic in_err_window(input logic [31:0] addr);
    return (addr >= ERR_LO) && (addr < ERR_LO + 32'h10);
  endfunction

  // expected target of a PC change
  function automatic logic [31:0] next_pc(input if_pkg::pc_sel_e sel);
    logic [31:0] t;
    case (sel)
      if_pkg::PC_BOOT: t = {boot_addr[31:8], 8'h80};
      if_pkg::PC_JUMP: t = branch_target;
      if_pkg::PC_ERET: t = mepc;
      default: begin
        if (exc_mux == if_pkg::EXC_PC_IRQ) t = {mtvec[31:8], 1'b0, irq_id, 2'b00};
        else t = {mtvec[31:8], 8'h00};
      end
    endcase
    return {t[31:2], 2'b00};
  endfunction

  // memory model, grant and response bookkeeping
  always @(posedge clk_i) begin
    int due;
    if (instr_rvalid_i) begin
      void'(rsp_addr_q.pop_front());
      void'(rsp_due_q.pop_front());
    end
    if (instr_req_o && instr_gnt_i) begin
      due = cyc + $urandom_range(3, 1);
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_addr_q.push_back(instr_addr_o);
      rsp_due_q.push_back(due);
      gnt_wait = $urandom_range(2, 0);
    end else if (instr_req_o && gnt_wait > 0) begin
      gnt_wait--;
    end
    cyc++;
  end

  always @(negedge clk_i) begin
    instr_gnt_i = (gnt_wait == 0);
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem_word(rsp_addr_q[0]);
      instr_err_i    = in_err_window(rsp_addr_q[0]);
    end else begin
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
    end
  end

  // compare every new instruction with the expected stream
  always @(posedge clk_i) begin
    if (rst_ni) begin
      assert (csr_mtvec_init_o == (pc_set && pc_mux == if_pkg::PC_BOOT)) else begin
        value_errs++;
        $display("ERR %0t: csr_mtvec_init_o is %b", $time, csr_mtvec_init_o);
      end
      if (instr_new_id_o) begin
        assert (pc_id_o == exp_pc) else begin
          value_errs++;
          $display("ERR %0t: pc %h, expected %h", $time, pc_id_o, exp_pc);
        end
        // the accepted word was the FIFO head one cycle earlier
        assert (last_pc_if == exp_pc) else begin
          value_errs++;
          $display("ERR %0t: pc_if %h, expected %h", $time, last_pc_if, exp_pc);
        end
        assert (instr_rdata_id_o == mem_word(exp_pc)) else begin
          value_errs++;
          $display("ERR %0t: instr %h, expected %h", $time, instr_rdata_id_o, mem_word(exp_pc));
        end
        assert (instr_fetch_err_o == in_err_window(exp_pc)) else begin
          value_errs++;
          $display("ERR %0t: fetch error %b at pc %h", $time, instr_fetch_err_o, exp_pc);
        end
        if (instr_fetch_err_o) err_seen++;
        exp_pc = exp_pc + 32'd4;
        new_count++;
      end
      if (pc_set) exp_pc = next_pc(pc_mux);
    end
    last_pc_if = pc_if_o;
  end

  task automatic tick();
    @(negedge clk_i);
    pc_set = 1'b0;
    instr_valid_clear_i = 1'b0;
    if (rand_ready) id_in_ready_i = ($urandom_range(3, 0) != 0);
  endtask

  task automatic set_pc(input if_pkg::pc_sel_e sel);
    tick();
    pc_mux = sel;
    pc_set = 1'b1;
  endtask

  task automatic wait_words(input int n);
    int start;
    int t;
    start = new_count;
    t = 0;
    while (new_count < start + n && t < 200) begin
      tick();
      t++;
    end
    if (new_count < start + n) begin
      timeouts++;
      $display("timeout at %0t: only %0d of %0d instructions arrived", $time,
               new_count - start, n);
    end
  endtask

  task automatic wait_busy();
    int t;
    t = 0;
    while (!if_busy_o && t < 50) begin
      tick();
      t++;
    end
    if (!if_busy_o) begin
      timeouts++;
      $display("timeout at %0t: no bus request went out", $time);
    end
  endtask

  initial begin
    void'($urandom(74));
    rst_ni = 1'b0;
    req_i = 1'b0;
    pc_set = 1'b0;
    pc_mux = if_pkg::PC_BOOT;
    exc_mux = if_pkg::EXC_PC_EXC;
    irq_id = '0;
    boot_addr = 32'h0000_1234;
    branch_target = '0;
    mepc = '0;
    mtvec = 32'h0000_4A00;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    rand_ready = 1'b0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    req_i = 1'b1;
    // idle until the first PC change
    repeat (3) begin
      tick();
      assert (!instr_req_o && !if_busy_o) else begin
        step_errs++;
        $display("ERR %0t: request %b busy %b before the first PC change", $time,
                 instr_req_o, if_busy_o);
      end
    end
    set_pc(if_pkg::PC_BOOT);
    wait_words(1);
    rand_ready = 1'b1;
    wait_words(12);
    // jump while the old stream is still on the bus
    wait_busy();
    branch_target = 32'h0000_2000;
    pc_mux = if_pkg::PC_JUMP;
    pc_set = 1'b1;
    wait_words(6);
    set_pc(if_pkg::PC_EXC);
    wait_words(4);
    exc_mux = if_pkg::EXC_PC_IRQ;
    irq_id = 5'd11;
    set_pc(if_pkg::PC_EXC);
    wait_words(4);
    mepc = 32'h0000_1F06;
    set_pc(if_pkg::PC_ERET);
    wait_words(4);
    branch_target = ERR_LO - 32'd8;
    set_pc(if_pkg::PC_JUMP);
    wait_words(8);
    assert (err_seen == 4) else begin
      step_errs++;
      $display("ERR %0t: %0d fetch errors seen, expected 4", $time, err_seen);
    end
    // valid hold and clear with the decode stage stalled
    rand_ready = 1'b0;
    tick();
    id_in_ready_i = 1'b0;
    repeat (3) tick();
    repeat (4) begin
      tick();
      assert (instr_valid_id_o && !instr_new_id_o) else begin
        step_errs++;
        $display("ERR %0t: valid %b new %b while stalled", $time, instr_valid_id_o,
                 instr_new_id_o);
      end
    end
    instr_valid_clear_i = 1'b1;
    tick();
    assert (!instr_valid_id_o) else begin
      step_errs++;
      $display("ERR %0t: valid still high after clear", $time);
    end
    id_in_ready_i = 1'b1;
    wait_words(2);
    tick();
    $display("value errors %0d, step errors %0d, timeouts %0d, assertion failures %0d",
             value_errs, step_errs, timeouts, uut.u_asserts.fail_count);
    if (value_errs == 0 && step_errs == 0 && timeouts == 0 && uut.u_asserts.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* common/if_pkg.sv */
// shared widths, constants and types for the instruction fetch stage
// address and instruction words, next-PC and exception target encodings

`default_nettype none

package if_pkg;

  // data path widths
  localparam int unsigned ADDR_W  = 32;
  localparam int unsigned INSTR_W = 32;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // low byte of the boot address
  localparam logic [7:0] BOOT_OFFSET = 8'h80;

  // trap vector bits replaced by the exception or interrupt offset
  localparam int unsigned VEC_LSB = 8;

  // interrupt identifier width, sized so that {1'b0, id, 2'b00} fills VEC_LSB bits
  localparam int unsigned IRQ_ID_W = 5;

  // fetch FIFO entries, also the limit on words in flight plus stored
  localparam int unsigned FIFO_DEPTH = 2;

  // outstanding and discard counters
  localparam int unsigned CNT_W = 2;

  // FIFO read and write pointers
  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

  // next-PC source
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_EXC  = 2'b10,
    PC_ERET = 2'b11
  } pc_sel_e;

  // exception target kind
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

endpackage

`default_nettype wire

/* prefetch/if_fetch_fifo.sv */
// circular FIFO of fetched words with address and bus error flag
// single cycle flush, which wins over push

`timescale 1ns/1ps
`default_nettype none

module if_fetch_fifo (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      push_i,
  input  if_pkg::instr_t            push_rdata_i,
  input  if_pkg::addr_t             push_addr_i,
  input  logic                      push_err_i,
  input  logic                      pop_i,
  output logic                      valid_o,
  output if_pkg::instr_t            rdata_o,
  output if_pkg::addr_t             addr_o,
  output logic                      err_o,
  output logic [if_pkg::CNT_W-1:0]  count_o
);
  import if_pkg::*;

  instr_t           data_q [FIFO_DEPTH];
  addr_t            addr_q [FIFO_DEPTH];
  logic             err_q  [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  assign valid_o = (count_q != '0);
  assign pop     = pop_i & valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      data_q[wr_ptr_q] <= push_rdata_i;
      addr_q[wr_ptr_q] <= push_addr_i;
      err_q[wr_ptr_q]  <= push_err_i;
    end
  end

  assign rdata_o = data_q[rd_ptr_q];
  assign addr_o  = addr_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

/* prefetch/if_prefetch_buffer.sv */
// prefetch buffer on the request/grant/response instruction bus
// request control, outstanding and discard counters, response address tracking

`timescale 1ns/1ps
`default_nettype none

module if_prefetch_buffer (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_i,
  input  logic           branch_i,
  input  if_pkg::addr_t  branch_addr_i,
  input  logic           ready_i,
  output logic           valid_o,
  output if_pkg::instr_t rdata_o,
  output if_pkg::addr_t  addr_o,
  output logic           err_o,
  output logic           busy_o,
  output logic           instr_req_o,
  output if_pkg::addr_t  instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  if_pkg::instr_t instr_rdata_i,
  input  logic           instr_err_i
);
  import if_pkg::*;

  logic             active_q;
  logic             hold_q;
  addr_t            next_addr_q;
  addr_t            hold_addr_q;
  addr_t            rsp_addr_q;
  logic [CNT_W-1:0] out_q, out_d;
  logic [CNT_W-1:0] disc_q, disc_d;
  logic [CNT_W-1:0] fifo_count;
  logic [CNT_W:0]   fill;
  logic             new_req;
  logic             rsp_keep;

  // words in flight plus words stored, bounded by the FIFO size
  assign fill    = {1'b0, out_q} + {1'b0, fifo_count};
  assign new_req = ~hold_q & active_q & req_i & ~branch_i & (fill < (CNT_W+1)'(FIFO_DEPTH));

  // an ungranted request keeps its address, even across a PC change
  assign instr_req_o  = hold_q | new_req;
  assign instr_addr_o = hold_q ? hold_addr_q : next_addr_q;

  // responses are in order, so stale ones always come first
  assign rsp_keep = instr_rvalid_i & (disc_q == '0);

  assign out_d = out_q + CNT_W'(new_req) - CNT_W'(instr_rvalid_i);

  always_comb begin
    if (branch_i) begin
      // everything still in flight belongs to the old stream
      disc_d = out_q - CNT_W'(instr_rvalid_i);
    end else if (instr_rvalid_i && disc_q != '0) begin
      disc_d = disc_q - CNT_W'(1);
    end else begin
      disc_d = disc_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      hold_q   <= 1'b0;
      out_q    <= '0;
      disc_q   <= '0;
    end else begin
      if (branch_i && req_i) begin
        active_q <= 1'b1;
      end
      hold_q <= instr_req_o & ~instr_gnt_i;
      out_q  <= out_d;
      disc_q <= disc_d;
    end
  end

  // next request address, and the address of the oldest kept request
  always_ff @(posedge clk_i) begin
    if (branch_i) begin
      next_addr_q <= branch_addr_i;
      rsp_addr_q  <= branch_addr_i;
    end else begin
      if (new_req) begin
        next_addr_q <= next_addr_q + ADDR_W'(4);
      end
      if (rsp_keep) begin
        rsp_addr_q <= rsp_addr_q + ADDR_W'(4);
      end
    end
    if (!hold_q) begin
      hold_addr_q <= next_addr_q;
    end
  end

  assign busy_o = (out_q != '0);

  if_fetch_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (branch_i),
    .push_i       (rsp_keep),
    .push_rdata_i (instr_rdata_i),
    .push_addr_i  (rsp_addr_q),
    .push_err_i   (instr_err_i),
    .pop_i        (ready_i),
    .valid_o      (valid_o),
    .rdata_o      (rdata_o),
    .addr_o       (addr_o),
    .err_o        (err_o),
    .count_o      (fifo_count)
  );

endmodule

`default_nettype wire

/* verilog.f */
common/if_pkg.sv
verilog/if_pc_select.sv
prefetch/if_fetch_fifo.sv
prefetch/if_prefetch_buffer.sv
verilog/if_id_register.sv
verilog/if_stage.sv
bench/if_stage_asserts.sv
bench/tb_if_stage.sv

/* verilog/if_id_register.sv */
// IF-ID pipeline register
// acceptance, valid and new flags, instruction, PC and fetch error

`timescale 1ns/1ps
`default_nettype none

module if_id_register (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           fetch_valid_i,
  input  if_pkg::instr_t fetch_rdata_i,
  input  if_pkg::addr_t  fetch_addr_i,
  input  logic           fetch_err_i,
  input  logic           id_in_ready_i,
  input  logic           pc_set_i,
  input  logic           instr_valid_clear_i,
  output logic           fetch_ready_o,
  output logic           instr_valid_id_o,
  output logic           instr_new_id_o,
  output if_pkg::instr_t instr_rdata_id_o,
  output logic           instr_fetch_err_o,
  output if_pkg::addr_t  pc_id_o
);

  logic accept;

  // a PC change squashes whatever the FIFO offers this cycle
  assign fetch_ready_o = id_in_ready_i & ~pc_set_i;
  assign accept        = fetch_valid_i & fetch_ready_o;

  // valid holds until cleared, new is a single cycle per accepted word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= accept | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= accept;
    end
  end

  // frozen while the decode stage stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      instr_fetch_err_o <= fetch_err_i;
      pc_id_o           <= fetch_addr_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/if_pc_select.sv */
// next fetch address selection
// exception and vectored interrupt targets, mtvec init request on boot

`timescale 1ns/1ps
`default_nettype none

module if_pc_select (
  input  if_pkg::pc_sel_e                pc_mux_i,
  input  if_pkg::exc_pc_sel_e            exc_pc_mux_i,
  input  logic [if_pkg::IRQ_ID_W-1:0]    irq_id_i,
  input  logic                           pc_set_i,
  input  if_pkg::addr_t                  boot_addr_i,
  input  if_pkg::addr_t                  branch_target_i,
  input  if_pkg::addr_t                  csr_mepc_i,
  input  if_pkg::addr_t                  csr_mtvec_i,
  output if_pkg::addr_t                  fetch_addr_n_o,
  output logic                           csr_mtvec_init_o
);
  import if_pkg::*;

  addr_t exc_pc;
  addr_t pc_mux;

  // trap entry, direct or vectored by interrupt id
  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_IRQ: exc_pc = {csr_mtvec_i[ADDR_W-1:VEC_LSB], 1'b0, irq_id_i, 2'b00};
      default:    exc_pc = {csr_mtvec_i[ADDR_W-1:VEC_LSB], {VEC_LSB{1'b0}}};
    endcase
  end

  always_comb begin
    case (pc_mux_i)
      PC_JUMP: pc_mux = branch_target_i;
      PC_EXC:  pc_mux = exc_pc;
      PC_ERET: pc_mux = csr_mepc_i;
      default: pc_mux = {boot_addr_i[ADDR_W-1:8], BOOT_OFFSET};
    endcase
  end

  // fetches are always word aligned
  assign fetch_addr_n_o = {pc_mux[ADDR_W-1:2], 2'b00};

  // CSR file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

`default_nettype wire

/* verilog/if_stage.sv */
// instruction fetch stage top level
// next-PC selection, prefetch buffer and IF-ID register

`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  if_pkg::addr_t               boot_addr_i,
  input  logic                        pc_set_i,
  input  if_pkg::pc_sel_e             pc_mux_i,
  input  if_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  logic [if_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  if_pkg::addr_t               branch_target_i,
  input  if_pkg::addr_t               csr_mepc_i,
  input  if_pkg::addr_t               csr_mtvec_i,
  output logic                        csr_mtvec_init_o,
  // instruction bus
  output logic                        instr_req_o,
  output if_pkg::addr_t               instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  if_pkg::instr_t              instr_rdata_i,
  input  logic                        instr_err_i,
  // decode stage side
  input  logic                        id_in_ready_i,
  input  logic                        instr_valid_clear_i,
  output logic                        instr_valid_id_o,
  output logic                        instr_new_id_o,
  output if_pkg::instr_t              instr_rdata_id_o,
  output logic                        instr_fetch_err_o,
  output if_pkg::addr_t               pc_id_o,
  output if_pkg::addr_t               pc_if_o,
  output logic                        if_busy_o
);
  import if_pkg::*;

  addr_t  fetch_addr_n;
  instr_t fetch_rdata;
  logic   fetch_valid;
  logic   fetch_err;
  logic   fetch_ready;

  if_pc_select u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // FIFO head address doubles as the IF stage PC
  if_prefetch_buffer u_prefetch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .branch_i       (pc_set_i),
    .branch_addr_i  (fetch_addr_n),
    .ready_i        (fetch_ready),
    .valid_o        (fetch_valid),
    .rdata_o        (fetch_rdata),
    .addr_o         (pc_if_o),
    .err_o          (fetch_err),
    .busy_o         (if_busy_o),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  if_id_register u_if_id (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (pc_if_o),
    .fetch_err_i         (fetch_err),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .fetch_ready_o       (fetch_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

endmodule

`default_nettype wire
